/* project.f */
+incdir+logic
logic/alert_pkg.sv
logic/csr_pkg.sv
logic/diff_decode.sv
logic/alert_sender.sv
logic/alert_receiver.sv
logic/alert_csr.sv
logic/alert_sub_top.sv
test/alert_properties.sv
test/alert_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the alert block simulation with Verilator and runs it
# the exit status is nonzero when the build or the run fails

cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
  --top-module alert_tb \
  -f project.f &&
./obj_dir/Valert_tb +verilator+error+limit+100 ||
{ echo "simulation did not pass"; exit 1; }

/* test/alert_tb.sv */
// testbench for the alert aggregation block
// loops every sender back into a receiver, drives the AXI4-Lite port
// and can break the looped alert pair to provoke integrity faults

`timescale 1ns/1ns

`include "alert_config.svh"

module alert_tb;

  localparam int unsigned NL = `NUM_LOCAL_ALERTS;
  // the tests take a few hundred cycles, so this leaves ample margin
  localparam int unsigned MAX_CYCLES = 2000;

  typedef logic [NL-1:0] lanes_t;

  localparam lanes_t         ALL_LANES = '1;
  localparam csr_pkg::data_t ALL_WORD  = csr_pkg::data_t'(ALL_LANES);
  // every access is answered with OKAY
  localparam csr_pkg::resp_t OKAY_RESP = 2'b00;

  logic clk;
  logic rst_n;
  lanes_t alert_req;
  lanes_t alert_ack;
  lanes_t fault_en;
  lanes_t alert_p_seen;
  lanes_t n_rails_high;
  alert_pkg::alert_tx_t [NL-1:0] tx_out;
  alert_pkg::alert_tx_t [NL-1:0] tx_loop;
  alert_pkg::alert_rx_t [NL-1:0] rx_out;
  csr_pkg::axil_req_t axil_req;
  csr_pkg::axil_rsp_t axil_rsp;
  logic irq;
  int unsigned cycle_count;

  ////////////////////////////////////////////////////////////////////////////
  // DUT and loopback
  ////////////////////////////////////////////////////////////////////////////

  always #50 clk = ~clk;

  alert_sub_top u_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .alert_req_i (alert_req),
    .alert_ack_o (alert_ack),
    .alert_tx_o  (tx_out),
    .alert_rx_i  (rx_out),
    .alert_tx_i  (tx_loop),
    .alert_rx_o  (rx_out),
    .axil_req_i  (axil_req),
    .axil_rsp_o  (axil_rsp),
    .irq_o       (irq)
  );

  bind alert_sub_top alert_properties u_props (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .tx_pairs_i (alert_tx_o),
    .rx_pairs_i (alert_rx_o),
    .axil_req_i (axil_req_i),
    .axil_rsp_i (axil_rsp_o),
    .alert_i    (alert),
    .ping_ok_i  (ping_ok),
    .rx_integ_i (rx_integ),
    .irq_i      (irq_o)
  );

  // a fault copies alert_p onto alert_n, so the pair reads equal
  always_comb begin
    for (int i = 0; i < NL; i++) begin
      tx_loop[i].alert_p = tx_out[i].alert_p;
      tx_loop[i].alert_n = fault_en[i] ? tx_out[i].alert_p : tx_out[i].alert_n;
      alert_p_seen[i]    = tx_out[i].alert_p;
      n_rails_high[i]    = tx_out[i].alert_n & rx_out[i].ack_n & rx_out[i].ping_n;
    end
  end

  // watchdog and bound assertion monitor
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > MAX_CYCLES) begin
      end_with_error("timeout, the tests did not finish within the cycle limit");
    end else if (u_dut.u_props.any_fail) begin
      end_with_error("a bound protocol assertion failed");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic lanes_t lane(input int unsigned k);
    return lanes_t'(1) << k;
  endfunction

  function automatic csr_pkg::data_t chan_word(input int unsigned k);
    return csr_pkg::data_t'(1) << k;
  endfunction

  task automatic end_with_error(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  // inputs move 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic compare_word(input string name, input csr_pkg::data_t exp,
                              input csr_pkg::data_t act);
    assert (act == exp) else begin
      end_with_error($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic axi_write(input csr_pkg::addr_t addr, input csr_pkg::data_t data);
    axil_req.aw_valid = 1'b1;
    axil_req.aw_addr  = addr;
    axil_req.w_valid  = 1'b1;
    axil_req.w_data   = data;
    axil_req.w_strb   = 4'hF;
    axil_req.b_ready  = 1'b1;
    while (!axil_rsp.aw_ready) begin
      next_cycle();
    end
    next_cycle();
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    while (!axil_rsp.b_valid) begin
      next_cycle();
    end
    compare_word("write response", csr_pkg::data_t'(OKAY_RESP),
                 csr_pkg::data_t'(axil_rsp.b_resp));
    next_cycle();
    axil_req.b_ready = 1'b0;
  endtask

  // rready stays low for stall cycles once the data is up
  task automatic axi_read(input csr_pkg::addr_t addr, input int unsigned stall,
                          output csr_pkg::data_t data);
    csr_pkg::data_t first;
    axil_req.ar_valid = 1'b1;
    axil_req.ar_addr  = addr;
    axil_req.r_ready  = (stall == 0);
    while (!axil_rsp.ar_ready) begin
      next_cycle();
    end
    next_cycle();
    axil_req.ar_valid = 1'b0;
    while (!axil_rsp.r_valid) begin
      next_cycle();
    end
    first = axil_rsp.r_data;
    compare_word("read response", csr_pkg::data_t'(OKAY_RESP),
                 csr_pkg::data_t'(axil_rsp.r_resp));
    repeat (stall) begin
      next_cycle();
      assert (axil_rsp.r_valid && axil_rsp.r_data == first) else begin
        end_with_error("rvalid or read data changed while rready was held low");
      end
    end
    axil_req.r_ready = 1'b1;
    next_cycle();
    axil_req.r_ready = 1'b0;
    data = first;
  endtask

  task automatic check_reg(input string name, input csr_pkg::addr_t addr,
                           input csr_pkg::data_t exp);
    csr_pkg::data_t act;
    axi_read(addr, 0, act);
    compare_word(name, exp, act);
  endtask

  task automatic pulse_alert(input lanes_t mask);
    alert_req = mask;
    next_cycle();
    alert_req = '0;
  endtask

  // acks are single pulses, collect them until every lane has shown one
  task automatic wait_acks(input lanes_t mask);
    lanes_t seen;
    seen = alert_ack & mask;
    while (seen != mask) begin
      next_cycle();
      seen = seen | (alert_ack & mask);
    end
  endtask

  // PING_REQ drops once the ping has answered
  task automatic wait_ping_done(input int unsigned k);
    csr_pkg::data_t rd;
    rd = chan_word(k);
    while ((rd & chan_word(k)) != '0) begin
      axi_read(`REG_PING_REQ, 0, rd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned first;
    int unsigned k;
    csr_pkg::data_t rd;
    void'($urandom(32'h9935));
    clk         = 1'b0;
    rst_n       = 1'b0;
    alert_req   = '0;
    fault_en    = '0;
    axil_req    = '0;
    cycle_count = 0;
    first       = $urandom % NL;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reset state
    assert (irq == 1'b0) else end_with_error("irq_o is high after reset");
    assert (n_rails_high == ALL_LANES) else end_with_error("an n rail is low after reset");
    check_reg("reset PING_REQ", `REG_PING_REQ, '0);
    check_reg("reset CAUSE", `REG_CAUSE, '0);
    check_reg("reset PING_OK", `REG_PING_OK, '0);
    check_reg("reset INTEG", `REG_INTEG, '0);

    // native alert on each channel, starting at a random one
    for (int unsigned i = 0; i < NL; i++) begin
      k = (first + i) % NL;
      pulse_alert(lane(k));
      wait_acks(lane(k));
      assert (irq == 1'b1) else end_with_error("irq_o did not rise after a native alert");
      check_reg("native CAUSE", `REG_CAUSE, chan_word(k));
      check_reg("native PING_OK", `REG_PING_OK, '0);
      axi_write(`REG_CAUSE, chan_word(k));
      check_reg("native cleared CAUSE", `REG_CAUSE, '0);
      assert (irq == 1'b0) else end_with_error("irq_o stayed high after CAUSE was cleared");
    end

    // all channels at once, then clear one bit and then the rest
    pulse_alert(ALL_LANES);
    wait_acks(ALL_LANES);
    check_reg("all CAUSE", `REG_CAUSE, ALL_WORD);
    axi_write(`REG_CAUSE, chan_word(first));
    check_reg("partial clear CAUSE", `REG_CAUSE, ALL_WORD & ~chan_word(first));
    assert (irq == 1'b1) else end_with_error("irq_o fell while a CAUSE bit was still set");
    axi_write(`REG_CAUSE, ALL_WORD);
    check_reg("full clear CAUSE", `REG_CAUSE, '0);
    assert (irq == 1'b0) else end_with_error("irq_o stayed high after CAUSE was cleared");

    // ping test, answered with a handshake that is not an alert
    for (int unsigned i = 0; i < NL; i++) begin
      k = (first + i) % NL;
      axi_write(`REG_PING_REQ, chan_word(k));
      wait_ping_done(k);
      check_reg("ping PING_OK", `REG_PING_OK, chan_word(k));
      check_reg("ping CAUSE", `REG_CAUSE, '0);
      check_reg("ping PING_REQ", `REG_PING_REQ, '0);
      axi_write(`REG_PING_OK, chan_word(k));
      check_reg("ping cleared PING_OK", `REG_PING_OK, '0);
    end

    // broken alert pair, the stalled handshake completes once the fault goes
    for (int unsigned i = 0; i < NL; i++) begin
      k = (first + i) % NL;
      fault_en = lane(k);
      pulse_alert(lane(k));
      while ((alert_p_seen & lane(k)) == '0) begin
        next_cycle();
      end
      repeat (3) next_cycle();
      // slow master on this read
      axi_read(`REG_INTEG, 4, rd);
      compare_word("fault INTEG", chan_word(k), rd);
      check_reg("fault CAUSE", `REG_CAUSE, '0);
      fault_en = '0;
      wait_acks(lane(k));
      check_reg("released CAUSE", `REG_CAUSE, chan_word(k));
      axi_write(`REG_INTEG, chan_word(k));
      axi_write(`REG_CAUSE, chan_word(k));
      check_reg("fault cleared INTEG", `REG_INTEG, '0);
      check_reg("fault cleared CAUSE", `REG_CAUSE, '0);
      assert (irq == 1'b0) else end_with_error("irq_o stayed high after CAUSE was cleared");
    end

    next_cycle();
    if (u_dut.u_props.any_fail == 1'b0) begin
      $display("Test OK");
      $finish;
    end else begin
      end_with_error("a bound protocol assertion failed");
    end
  end

endmodule

/* test/alert_properties.sv */
// concurrent checks on the alert pairs, the register port and the event wires
// of the alert block top level, attached to it with bind from the testbench

`timescale 1ns/1ns

`include "alert_config.svh"

module alert_properties (
  input logic                                         clk_i,
  input logic                                         rst_ni,
  input alert_pkg::alert_tx_t [`NUM_LOCAL_ALERTS-1:0] tx_pairs_i,
  input alert_pkg::alert_rx_t [`NUM_EXT_ALERTS-1:0]   rx_pairs_i,
  input csr_pkg::axil_req_t                           axil_req_i,
  input csr_pkg::axil_rsp_t                           axil_rsp_i,
  input logic [`NUM_EXT_ALERTS-1:0]                   alert_i,
  input logic [`NUM_EXT_ALERTS-1:0]                   ping_ok_i,
  input logic [`NUM_EXT_ALERTS-1:0]                   rx_integ_i,
  input logic                                         irq_i
);

  logic [`NUM_LOCAL_ALERTS-1:0] tx_ok;
  logic [`NUM_EXT_ALERTS-1:0]   rx_ok;
  logic tx_fail = 1'b0;
  logic rx_fail = 1'b0;
  logic b_fail = 1'b0;
  logic r_fail = 1'b0;
  logic irq_fail = 1'b0;
  logic event_fail = 1'b0;
  logic any_fail;

  assign any_fail = tx_fail | rx_fail | b_fail | r_fail | irq_fail | event_fail;

  ////////////////////////////////////////////////////////////////////////////
  // pair encoding
  ////////////////////////////////////////////////////////////////////////////

  // a pair is valid while its rails differ
  for (genvar k = 0; k < `NUM_LOCAL_ALERTS; k++) begin : gen_tx
    assign tx_ok[k] = tx_pairs_i[k].alert_p ^ tx_pairs_i[k].alert_n;
  end

  // both the ping and the ack pair of each incoming channel
  for (genvar k = 0; k < `NUM_EXT_ALERTS; k++) begin : gen_rx
    assign rx_ok[k] = (rx_pairs_i[k].ping_p ^ rx_pairs_i[k].ping_n) &
                      (rx_pairs_i[k].ack_p ^ rx_pairs_i[k].ack_n);
  end

  tx_pair_complement: assert property (@(posedge clk_i) disable iff (!rst_ni) &tx_ok)
    else begin
      tx_fail = 1'b1;
      $error("an outgoing alert pair has equal rails");
    end

  rx_pair_complement: assert property (@(posedge clk_i) disable iff (!rst_ni) &rx_ok)
    else begin
      rx_fail = 1'b1;
      $error("a ping or ack pair has equal rails");
    end

  ////////////////////////////////////////////////////////////////////////////
  // bus responses
  ////////////////////////////////////////////////////////////////////////////

  // write response waits for bready
  b_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_rsp_i.b_valid && !axil_req_i.b_ready |=> axil_rsp_i.b_valid)
    else begin
      b_fail = 1'b1;
      $error("bvalid dropped before bready");
    end

  // read data frozen while rready is low
  r_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_rsp_i.r_valid && !axil_req_i.r_ready |=>
    axil_rsp_i.r_valid && $stable(axil_rsp_i.r_data))
    else begin
      r_fail = 1'b1;
      $error("rvalid or rdata changed before rready");
    end

  ////////////////////////////////////////////////////////////////////////////
  // events and interrupt
  ////////////////////////////////////////////////////////////////////////////

  // any alert pulse lands in cause, so irq is up a cycle later
  irq_after_alert: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |alert_i |=> irq_i)
    else begin
      irq_fail = 1'b1;
      $error("irq_o did not follow an alert pulse");
    end

  // a ping response or an integrity fault alone leaves the interrupt low
  irq_needs_alert: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !irq_i && (alert_i == '0) && ((ping_ok_i | rx_integ_i) != '0) |=> !irq_i)
    else begin
      event_fail = 1'b1;
      $error("irq_o rose on a ping response or an integrity fault");
    end

endmodule

/* logic/alert_sub_top.sv */
// top level of the alert aggregation block
// one sender per local alert source, one receiver per incoming channel,
// and the register slave that collects their events

`timescale 1ns/1ns

`include "alert_config.svh"

module alert_sub_top (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic [`NUM_LOCAL_ALERTS-1:0]                 alert_req_i,
  output logic [`NUM_LOCAL_ALERTS-1:0]                 alert_ack_o,
  output alert_pkg::alert_tx_t [`NUM_LOCAL_ALERTS-1:0] alert_tx_o,
  input  alert_pkg::alert_rx_t [`NUM_LOCAL_ALERTS-1:0] alert_rx_i,
  input  alert_pkg::alert_tx_t [`NUM_EXT_ALERTS-1:0]   alert_tx_i,
  output alert_pkg::alert_rx_t [`NUM_EXT_ALERTS-1:0]   alert_rx_o,
  input  csr_pkg::axil_req_t                           axil_req_i,
  output csr_pkg::axil_rsp_t                           axil_rsp_o,
  output logic                                         irq_o
);

  // event wires between the channels and the register slave
  logic [`NUM_EXT_ALERTS-1:0]   ping_req, ping_ok, alert, rx_integ;
  logic [`NUM_LOCAL_ALERTS-1:0] tx_integ;

  for (genvar k = 0; k < `NUM_LOCAL_ALERTS; k++) begin : gen_sender
    alert_sender u_sender (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .alert_req_i  (alert_req_i[k]),
      .alert_ack_o  (alert_ack_o[k]),
      .integ_fail_o (tx_integ[k]),
      .alert_rx_i   (alert_rx_i[k]),
      .alert_tx_o   (alert_tx_o[k])
    );
  end

  for (genvar k = 0; k < `NUM_EXT_ALERTS; k++) begin : gen_receiver
    alert_receiver u_receiver (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .ping_req_i   (ping_req[k]),
      .ping_ok_o    (ping_ok[k]),
      .integ_fail_o (rx_integ[k]),
      .alert_o      (alert[k]),
      .alert_rx_o   (alert_rx_o[k]),
      .alert_tx_i   (alert_tx_i[k])
    );
  end

  alert_csr u_csr (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .ping_req_o (ping_req),
    .ping_ok_i  (ping_ok),
    .alert_i    (alert),
    .rx_integ_i (rx_integ),
    .tx_integ_i (tx_integ),
    .irq_o      (irq_o)
  );

endmodule

/* logic/alert_csr.sv */
// AXI4-Lite register slave of the alert block
// holds ping requests, sticky alert causes, ping-ok and integrity bits,
// and raises the interrupt while any cause bit is set

`timescale 1ns/1ns

`include "alert_config.svh"

module alert_csr (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  csr_pkg::axil_req_t           axil_req_i,
  output csr_pkg::axil_rsp_t           axil_rsp_o,
  output logic [`NUM_EXT_ALERTS-1:0]   ping_req_o,
  input  logic [`NUM_EXT_ALERTS-1:0]   ping_ok_i,
  input  logic [`NUM_EXT_ALERTS-1:0]   alert_i,
  input  logic [`NUM_EXT_ALERTS-1:0]   rx_integ_i,
  input  logic [`NUM_LOCAL_ALERTS-1:0] tx_integ_i,
  output logic                         irq_o
);

  localparam int unsigned NE = `NUM_EXT_ALERTS;
  localparam int unsigned NL = `NUM_LOCAL_ALERTS;

  logic          wr_en, rd_en;
  logic          bvalid_q, rvalid_q;
  csr_pkg::data_t wmask, wbits, rdata, rdata_q;
  logic [NE-1:0] ping_wr, cause_wr, pok_wr, integ_rx_wr;
  logic [NL-1:0] integ_tx_wr;
  logic [NE-1:0] ping_req_d, ping_req_q;
  logic [NE-1:0] cause_d, cause_q;
  logic [NE-1:0] pok_d, pok_q;
  logic [NE-1:0] integ_rx_d, integ_rx_q;
  logic [NL-1:0] integ_tx_d, integ_tx_q;
  logic          irq_q;

  ////////////////////////////////////////////////////////////////////////////
  // bus handshake
  ////////////////////////////////////////////////////////////////////////////

  // address and data are taken together, and not while a response waits
  assign wr_en = axil_req_i.aw_valid & axil_req_i.w_valid & ~bvalid_q;
  // one read in flight at a time
  assign rd_en = axil_req_i.ar_valid & ~rvalid_q;

  assign axil_rsp_o.aw_ready = wr_en;
  assign axil_rsp_o.w_ready  = wr_en;
  assign axil_rsp_o.b_valid  = bvalid_q;
  assign axil_rsp_o.b_resp   = csr_pkg::RESP_OKAY;
  assign axil_rsp_o.ar_ready = ~rvalid_q;
  assign axil_rsp_o.r_valid  = rvalid_q;
  assign axil_rsp_o.r_data   = rdata_q;
  assign axil_rsp_o.r_resp   = csr_pkg::RESP_OKAY;

  // byte strobes to a bit mask
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      wmask[8*i +: 8] = {8{axil_req_i.w_strb[i]}};
    end
  end

  assign wbits = axil_req_i.w_data & wmask;

  // per-register write bits, zero unless that register is addressed
  assign ping_wr     = (wr_en && axil_req_i.aw_addr == `REG_PING_REQ) ? wbits[NE-1:0] : '0;
  assign cause_wr    = (wr_en && axil_req_i.aw_addr == `REG_CAUSE) ? wbits[NE-1:0] : '0;
  assign pok_wr      = (wr_en && axil_req_i.aw_addr == `REG_PING_OK) ? wbits[NE-1:0] : '0;
  assign integ_rx_wr = (wr_en && axil_req_i.aw_addr == `REG_INTEG) ? wbits[NE-1:0] : '0;
  assign integ_tx_wr = (wr_en && axil_req_i.aw_addr == `REG_INTEG) ? wbits[16 +: NL] : '0;

  ////////////////////////////////////////////////////////////////////////////
  // register updates
  ////////////////////////////////////////////////////////////////////////////

  // ping request is set by software and dropped once the ping answers
  assign ping_req_d = (ping_req_q | ping_wr) & ~ping_ok_i;

  // sticky bits, write one to clear, a new event beats the clear
  assign cause_d    = (cause_q & ~cause_wr) | alert_i;
  assign pok_d      = (pok_q & ~pok_wr) | ping_ok_i;
  assign integ_rx_d = (integ_rx_q & ~integ_rx_wr) | rx_integ_i;
  assign integ_tx_d = (integ_tx_q & ~integ_tx_wr) | tx_integ_i;

  assign ping_req_o = ping_req_q;
  assign irq_o      = irq_q;

  // read data mux, unmapped offsets read zero
  always_comb begin
    rdata = '0;
    case (axil_req_i.ar_addr)
      `REG_PING_REQ: rdata[NE-1:0] = ping_req_q;
      `REG_CAUSE:    rdata[NE-1:0] = cause_q;
      `REG_PING_OK:  rdata[NE-1:0] = pok_q;
      `REG_INTEG: begin
        // receiver faults low, sender faults from bit 16
        rdata[NE-1:0]  = integ_rx_q;
        rdata[16 +: NL] = integ_tx_q;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_q   <= 1'b0;
      rvalid_q   <= 1'b0;
      ping_req_q <= '0;
      cause_q    <= '0;
      pok_q      <= '0;
      integ_rx_q <= '0;
      integ_tx_q <= '0;
      irq_q      <= 1'b0;
    end else begin
      // responses stay up until the master takes them
      if (wr_en) begin
        bvalid_q <= 1'b1;
      end else if (axil_req_i.b_ready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_en) begin
        rvalid_q <= 1'b1;
      end else if (axil_req_i.r_ready) begin
        rvalid_q <= 1'b0;
      end
      ping_req_q <= ping_req_d;
      cause_q    <= cause_d;
      pok_q      <= pok_d;
      integ_rx_q <= integ_rx_d;
      integ_tx_q <= integ_tx_d;
      // interrupt tracks cause in the same cycle the bit lands
      irq_q      <= |cause_d;
    end
  end

  // read data only changes on acceptance
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata;
    end
  end

endmodule

/* logic/alert_receiver.sv */
// receiver end of one incoming alert channel
// acks each handshake on the alert pair and reports it as an alert or a ping
// response, and sends pings by toggling the ping pair

`timescale 1ns/1ns

module alert_receiver (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 ping_req_i,
  output logic                 ping_ok_o,
  output logic                 integ_fail_o,
  output logic                 alert_o,
  output alert_pkg::alert_rx_t alert_rx_o,
  input  alert_pkg::alert_tx_t alert_tx_i
);

  logic alert_level, alert_sigint;
  logic ping_req_q, ping_rise;
  logic ping_tog_d, ping_tog_pq, ping_tog_nq;
  logic ping_pending_d, ping_pending_q;
  logic ack_d, ack_pq, ack_nq;
  alert_pkg::rx_state_e state_d, state_q;

  ////////////////////////////////////////////////////////////////////////////
  // decode the alert pair
  ////////////////////////////////////////////////////////////////////////////

  diff_decode u_decode_alert (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .diff_p_i (alert_tx_i.alert_p),
    .diff_n_i (alert_tx_i.alert_n),
    .level_o  (alert_level),
    .sigint_o (alert_sigint)
  );

  ////////////////////////////////////////////////////////////////////////////
  // ping request
  ////////////////////////////////////////////////////////////////////////////

  // only the rising edge counts as a new ping
  assign ping_rise  = ping_req_i & ~ping_req_q;
  assign ping_tog_d = ping_rise ? ~ping_tog_pq : ping_tog_pq;

  // pending is set on the rise only, so a request held high
  // cannot turn every native alert into a ping response
  assign ping_pending_d = ping_rise | (~ping_ok_o & ping_req_i & ping_pending_q);

  assign alert_rx_o.ping_p = ping_tog_pq;
  assign alert_rx_o.ping_n = ping_tog_nq;
  assign alert_rx_o.ack_p  = ack_pq;
  assign alert_rx_o.ack_n  = ack_nq;

  ////////////////////////////////////////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  // alert decode is combinational, so alert_o and ping_ok_o
  // pulse in the cycle that alert_p rises at the input
  always_comb begin
    state_d      = state_q;
    ack_d        = 1'b0;
    ping_ok_o    = 1'b0;
    integ_fail_o = 1'b0;
    alert_o      = 1'b0;

    unique case (state_q)
      alert_pkg::rx_idle: begin
        if (alert_level) begin
          state_d = alert_pkg::rx_ack_wait;
          ack_d   = 1'b1;
          if (ping_pending_q) begin
            ping_ok_o = 1'b1;
          end else begin
            alert_o = 1'b1;
          end
        end
      end
      // keep ack high until the sender drops alert
      alert_pkg::rx_ack_wait: begin
        if (!alert_level) begin
          state_d = alert_pkg::rx_pause0;
        end else begin
          ack_d = 1'b1;
        end
      end
      // two idle cycles between back-to-back handshakes
      alert_pkg::rx_pause0: begin
        state_d = alert_pkg::rx_pause1;
      end
      alert_pkg::rx_pause1: begin
        state_d = alert_pkg::rx_idle;
      end
      default: begin
        state_d = alert_pkg::rx_idle;
      end
    endcase

    // integrity fault wins over everything
    if (alert_sigint) begin
      state_d      = alert_pkg::rx_idle;
      ack_d        = 1'b0;
      ping_ok_o    = 1'b0;
      alert_o      = 1'b0;
      integ_fail_o = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= alert_pkg::rx_idle;
      ack_pq         <= 1'b0;
      ack_nq         <= 1'b1;
      ping_tog_pq    <= 1'b0;
      ping_tog_nq    <= 1'b1;
      ping_req_q     <= 1'b0;
      ping_pending_q <= 1'b0;
    end else begin
      state_q        <= state_d;
      ack_pq         <= ack_d;
      ack_nq         <= ~ack_d;
      ping_tog_pq    <= ping_tog_d;
      ping_tog_nq    <= ~ping_tog_d;
      ping_req_q     <= ping_req_i;
      ping_pending_q <= ping_pending_d;
    end
  end

endmodule

/* logic/alert_sender.sv */
// sender end of one alert channel
// turns a local alert request into a four-phase handshake on the alert pair
// and answers each ping toggle from the receiver with a full handshake

`timescale 1ns/1ns

module alert_sender (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 alert_req_i,
  output logic                 alert_ack_o,
  output logic                 integ_fail_o,
  input  alert_pkg::alert_rx_t alert_rx_i,
  output alert_pkg::alert_tx_t alert_tx_o
);

  logic ping_level, ping_sigint;
  logic ack_level, ack_sigint;
  logic ping_level_q, ping_event;
  logic alert_pend_d, alert_pend_q;
  logic ping_pend_d, ping_pend_q;
  logic hs_native_d, hs_native_q;
  logic alert_d, alert_pq, alert_nq;
  alert_pkg::tx_state_e state_d, state_q;

  ////////////////////////////////////////////////////////////////////////////
  // decode the ping and ack pairs
  ////////////////////////////////////////////////////////////////////////////

  diff_decode u_decode_ping (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .diff_p_i (alert_rx_i.ping_p),
    .diff_n_i (alert_rx_i.ping_n),
    .level_o  (ping_level),
    .sigint_o (ping_sigint)
  );

  diff_decode u_decode_ack (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .diff_p_i (alert_rx_i.ack_p),
    .diff_n_i (alert_rx_i.ack_n),
    .level_o  (ack_level),
    .sigint_o (ack_sigint)
  );

  // a ping is any change of level on the ping pair
  assign ping_event = ping_level ^ ping_level_q;

  assign integ_fail_o = ping_sigint | ack_sigint;

  assign alert_tx_o.alert_p = alert_pq;
  assign alert_tx_o.alert_n = alert_nq;

  ////////////////////////////////////////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    alert_d      = 1'b0;
    alert_ack_o  = 1'b0;
    hs_native_d  = hs_native_q;
    // requests arriving mid-handshake wait for the next one
    alert_pend_d = alert_pend_q | alert_req_i;
    ping_pend_d  = ping_pend_q | ping_event;

    unique case (state_q)
      alert_pkg::tx_idle: begin
        // native alerts go first, a ping waits one handshake
        if (alert_pend_d) begin
          state_d      = alert_pkg::tx_alert_high;
          alert_d      = 1'b1;
          hs_native_d  = 1'b1;
          alert_pend_d = 1'b0;
        end else if (ping_pend_d) begin
          state_d     = alert_pkg::tx_alert_high;
          alert_d     = 1'b1;
          hs_native_d = 1'b0;
          ping_pend_d = 1'b0;
        end
      end
      // hold alert until the receiver acks
      alert_pkg::tx_alert_high: begin
        alert_d = 1'b1;
        if (ack_level) begin
          state_d = alert_pkg::tx_alert_low;
          alert_d = 1'b0;
        end
      end
      // wait for ack to drop, which completes the handshake
      alert_pkg::tx_alert_low: begin
        if (!ack_level) begin
          state_d     = alert_pkg::tx_pause;
          alert_ack_o = hs_native_q;
        end
      end
      alert_pkg::tx_pause: begin
        state_d = alert_pkg::tx_idle;
      end
      default: begin
        state_d = alert_pkg::tx_idle;
      end
    endcase

    // a broken ack pair aborts the handshake
    if (ack_sigint) begin
      state_d     = alert_pkg::tx_idle;
      alert_d     = 1'b0;
      alert_ack_o = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= alert_pkg::tx_idle;
      alert_pq     <= 1'b0;
      alert_nq     <= 1'b1;
      ping_level_q <= 1'b0;
      alert_pend_q <= 1'b0;
      ping_pend_q  <= 1'b0;
      hs_native_q  <= 1'b0;
    end else begin
      state_q      <= state_d;
      alert_pq     <= alert_d;
      alert_nq     <= ~alert_d;
      ping_level_q <= ping_level;
      alert_pend_q <= alert_pend_d;
      ping_pend_q  <= ping_pend_d;
      hs_native_q  <= hs_native_d;
    end
  end

endmodule

/* logic/diff_decode.sv */
// decoder for one differential pair in synchronous mode
// gives the encoded level and flags a pair whose rails are equal

`timescale 1ns/1ns

module diff_decode (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic diff_p_i,
  input  logic diff_n_i,
  output logic level_o,
  output logic sigint_o
);

  // last level seen on a correctly encoded pair
  logic level_q;

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  // equal rails mean a broken or tampered pair
  assign sigint_o = (diff_p_i == diff_n_i);

  // during a fault the level freezes, so no edge is seen downstream
  assign level_o = sigint_o ? level_q : diff_p_i;

  ////////////////////////////////////////////////////////////////////////////
  // state
  ////////////////////////////////////////////////////////////////////////////

  // reset value matches the idle level of every pair
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      level_q <= 1'b0;
    end else begin
      level_q <= level_o;
    end
  end

endmodule

/* logic/csr_pkg.sv */
// AXI4-Lite types of the register port
// the request bundles everything the master drives, the response the slave

package csr_pkg;

  // byte address and data word of the register port
  typedef logic [7:0]  addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;

  // the slave never reports an error
  localparam resp_t RESP_OKAY = 2'b00;

  // master to slave
  typedef struct packed {
    logic  aw_valid;
    addr_t aw_addr;
    logic  w_valid;
    data_t w_data;
    strb_t w_strb;
    logic  b_ready;
    logic  ar_valid;
    addr_t ar_addr;
    logic  r_ready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic  aw_ready;
    logic  w_ready;
    logic  b_valid;
    resp_t b_resp;
    logic  ar_ready;
    logic  r_valid;
    data_t r_data;
    resp_t r_resp;
  } axil_rsp_t;

endpackage

/* logic/alert_pkg.sv */
// types for the differential alert protocol
// the pair structs and the FSM encodings of both ends of a channel

package alert_pkg;

  // alert pair, driven by the sender toward the handler
  typedef struct packed {
    logic alert_p;
    logic alert_n;
  } alert_tx_t;

  // ping and ack pairs, driven by the receiver back to the sender
  typedef struct packed {
    logic ping_p;
    logic ping_n;
    logic ack_p;
    logic ack_n;
  } alert_rx_t;

  // receiver side of the four-phase handshake
  typedef enum logic [1:0] {
    rx_idle,
    rx_ack_wait,
    rx_pause0,
    rx_pause1
  } rx_state_e;

  // sender side of the four-phase handshake
  typedef enum logic [1:0] {
    tx_idle,
    tx_alert_high,
    tx_alert_low,
    tx_pause
  } tx_state_e;

endpackage

/* logic/alert_config.svh */
// channel counts and register map of the alert aggregation block
// include this wherever a channel width or a register offset is needed

`ifndef ALERT_CONFIG_SVH
`define ALERT_CONFIG_SVH

// outgoing sender channels, one per local peripheral
`define NUM_LOCAL_ALERTS 2

// incoming receiver channels from other blocks
// loopback testing needs this equal to the sender count
`define NUM_EXT_ALERTS 2

// byte offsets on the AXI4-Lite register port
`define REG_PING_REQ 8'h00
`define REG_CAUSE    8'h04
`define REG_PING_OK  8'h08
`define REG_INTEG    8'h0C

`endif
